// ==== Makefile ====
TOP = SqrTb

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/SqrTb.sv ====
// Testbench for the pipelined signed squarer
// Table-driven operands through the req/ack ports, in-order result checks,
// handshake protocol monitor, back-pressure and latency checks

`timescale 1ns/1ps
`include "sqr_defs.svh"

module SqrTb;

	localparam int fixedRows = 9;
	localparam int numRows = fixedRows + 20;
	localparam int maxAckDelay = 6;
	localparam int timeoutNs = numRows * (maxAckDelay + 20) * 10;
	// Pipeline depth plus sender turnaround
	localparam int drainCycles = 8;

	logic clk;
	logic rst;
	logic reqIn;
	logic ackIn;
	logic reqOut;
	logic ackOut;
	SqrPkg::operand_t xIn;
	SqrPkg::result_t yOut;

	// Stimulus table of operand, expected square and ack delay
	logic [`SQR_WIDTH-1:0] opTab [numRows];
	logic [`SQR_RES_WIDTH-1:0] expTab [numRows];
	int delayTab [numRows];

	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int accepted = 0;
	int retired = 0;
	int maxInFlight = 0;
	int cycle = 0;
	int riseCycle;
	int riseTimes [$];
	logic prevReqIn = 1'b0;
	logic prevAckIn = 1'b0;
	logic prevReqOut = 1'b0;
	logic prevAckOut = 1'b0;
	SqrPkg::result_t prevYOut;

	SqrTop dut_i (
		.clk(clk), .rst(rst), .reqIn(reqIn), .ackIn(ackIn), .xIn(xIn),
		.reqOut(reqOut), .ackOut(ackOut), .yOut(yOut)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		lfsrStep = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic buildTable();
		// 0 1 -1 2 127 -127 -128 85 -86
		logic [`SQR_WIDTH-1:0] fixedOps [fixedRows] = '{8'h00, 8'h01, 8'hff, 8'h02,
			8'h7f, 8'h81, 8'h80, 8'h55, 8'haa};
		logic [31:0] lfsr;
		logic signed [`SQR_RES_WIDTH-1:0] wide;
		lfsr = 32'h5d96;
		for (int i = 0; i < numRows; i++) begin
			if (i < fixedRows) begin
				opTab[i] = fixedOps[i];
				delayTab[i] = i % (maxAckDelay + 1);
			end else begin
				// One LFSR step per operand bit
				for (int b = 0; b < `SQR_WIDTH; b++) begin
					lfsr = lfsrStep(lfsr);
					opTab[i][b] = lfsr[0];
				end
				// First half back-to-back and second half stalls the output
				delayTab[i] = (i < fixedRows + 10) ? 0 : maxAckDelay;
			end
			// Signed square over the result width
			wide = {{`SQR_WIDTH{opTab[i][`SQR_WIDTH-1]}}, opTab[i]};
			expTab[i] = wide * wide;
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %0t %s expected %0h got %0h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic flagError(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errorCount++;
	endtask

	task automatic waitCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic finishTest(input string name, input int errBefore);
		if (errorCount == errBefore) begin
			passCount++;
			$display("Test %s: ok", name);
		end else begin
			failCount++;
			$display("Test %s: errors", name);
		end
	endtask

	task automatic driveOperands();
		for (int i = 0; i < numRows; i++) begin
			reqIn = 1'b1;
			xIn.x = opTab[i];
			do waitCycle(); while (!ackIn);
			reqIn = 1'b0;
			do waitCycle(); while (ackIn);
		end
	endtask

	task automatic collectResults();
		SqrPkg::result_t got;
		int errBefore;
		for (int i = 0; i < numRows; i++) begin
			errBefore = errorCount;
			do waitCycle(); while (!reqOut);
			got = yOut;
			repeat (delayTab[i]) waitCycle();
			ackOut = 1'b1;
			retired++;
			do waitCycle(); while (reqOut);
			ackOut = 1'b0;
			checkValue("yOut", expTab[i], got.square);
			finishTest($sformatf("row %0d x=%0d", i, $signed(opTab[i])), errBefore);
		end
	endtask

	////////////////////////////////////////
	// Protocol monitor sampled mid-cycle
	////////////////////////////////////////

	// Handshake inputs seen at the last clock edge are the prev values
	always @(negedge clk) begin
		if (!rst) begin
			if (ackIn && !prevAckIn) begin
				if (!prevReqIn) flagError("ackIn rose while reqIn was low");
				accepted++;
				riseTimes.push_back(cycle);
				// Three stage registers plus the sender's holding register
				if (accepted - retired > 4) flagError("ackIn rose with the pipeline full");
				if (accepted - retired > maxInFlight) maxInFlight = accepted - retired;
			end
			if (!ackIn && prevAckIn && prevReqIn) flagError("ackIn fell while reqIn was high");
			if (reqOut && !prevReqOut) begin
				if (riseTimes.size() == 0) begin
					flagError("reqOut rose with no operand accepted");
				end else begin
					riseCycle = riseTimes.pop_front();
					if (cycle - riseCycle < 3) flagError("result appeared in under three cycles");
				end
			end
			if (!reqOut && prevReqOut && !prevAckOut) flagError("reqOut fell before ackOut rose");
			if (reqOut && prevReqOut && yOut !== prevYOut) flagError("yOut changed during request");
		end
		prevReqIn = reqIn;
		prevAckIn = ackIn;
		prevReqOut = reqOut;
		prevAckOut = ackOut;
		prevYOut = yOut;
	end

	// Watchdog
	initial begin
		#(timeoutNs + 100);
		$display("Timeout: run did not complete within %0d ns", timeoutNs + 100);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int errBefore;
		rst = 1'b1;
		reqIn = 1'b0;
		ackOut = 1'b0;
		xIn = '0;
		buildTable();
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;

		errBefore = errorCount;
		checkValue("ackIn", 0, ackIn);
		checkValue("reqOut", 0, reqOut);
		finishTest("reset", errBefore);

		fork
			driveOperands();
			collectResults();
		join

		// No result lost or duplicated and pipeline filled under stall
		errBefore = errorCount;
		checkValue("accepted", numRows, accepted);
		// A duplicate result would surface within the pipeline depth
		repeat (drainCycles) waitCycle();
		checkValue("reqOut", 0, reqOut);
		if (maxInFlight < 3) flagError("back-pressure never filled the pipeline");
		finishTest("back-pressure and protocol", errBefore);

		$display("Summary: %0d tests ok, %0d tests with errors, %0d errors",
			passCount, failCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/SqrPkg.sv
verilog/SqrPPGenSgn.sv
verilog/SqrCsaTree.sv
verilog/SqrPrefixAdder.sv
verilog/SqrPipeReg.sv
verilog/SqrReqAckIn.sv
verilog/SqrReqAckOut.sv
verilog/SqrTop.sv
bench/SqrTb.sv

// ==== verilog/SqrCsaTree.sv ====
// Carry-save reduction tree
// Compresses the partial-product rows with 3:2 full-adder levels
// until a single sum/carry pair remains

`timescale 1ns/1ps
`include "sqr_defs.svh"

module SqrCsaTree (
	input logic [`SQR_PP_ROWS*`SQR_RES_WIDTH-1:0] pp,
	output SqrPkg::csPair_t cs
);

	localparam int resW = `SQR_RES_WIDTH;
	// One level per row beyond the first two
	localparam int levels = `SQR_PP_ROWS - 2;

	wire [levels:0][resW-1:0] sumL;
	wire [levels:0][resW-1:0] carryL;

	// First two rows seed the redundant pair
	assign sumL[0] = pp[0 +: resW];
	assign carryL[0] = pp[resW +: resW];

	genvar lvl;
	genvar b;
	generate
		for (lvl = 1; lvl <= levels; lvl++) begin : gLevel
			// Next row folded in at this level
			wire [resW-1:0] addend;
			assign addend = pp[(lvl+1)*resW +: resW];
			assign carryL[lvl][0] = 1'b0;

			for (b = 0; b < resW; b++) begin : gBit
				// Full-adder sum stays in its column
				assign sumL[lvl][b] = sumL[lvl-1][b] ^ carryL[lvl-1][b] ^ addend[b];
				// Carry moves up one column, top carry dropped
				if (b < resW - 1) begin : gCarry
					assign carryL[lvl][b+1] = (sumL[lvl-1][b] & carryL[lvl-1][b]) |
						(sumL[lvl-1][b] & addend[b]) |
						(carryL[lvl-1][b] & addend[b]);
				end
			end
		end
	endgenerate

	assign cs = '{sum: sumL[levels], carry: carryL[levels]};

endmodule

// ==== verilog/SqrPPGenSgn.sv ====
// Signed squarer partial-product generator
// Folds symmetric cross products, places diagonal bits and adds
// two's-complement sign correction; rows packed LSB row first

`timescale 1ns/1ps

module SqrPPGenSgn #(
	parameter width = 8
) (
	input logic [width-1:0] X,
	output logic [(width/2+1)*2*width-1:0] PP
);

	// Row width and row count
	localparam resW = 2*width;
	localparam rows = width/2 + 1;

	logic [rows*resW-1:0] rowBits;

	always_comb begin
		rowBits = '0;

		////////////////////////////////////////
		// Cross products, unsigned part
		////////////////////////////////////////

		// x(i)x(k) appears twice, so weight shifts up by one
		for (int r = 0; r < (width-1)/2; r++) begin
			for (int c = r + 1; c < width - r - 1; c++) begin
				rowBits[r*resW + r + c + 1] = X[r] & X[c];
			end
		end

		////////////////////////////////////////
		// Cross products with sign bits
		////////////////////////////////////////

		// MSB terms inverted, constants added below
		for (int c = 0; c < width - 1; c++) begin
			rowBits[width + c] = X[width-1] & ~X[c];
		end
		// Remaining upper triangle
		for (int r = 1; r < width/2; r++) begin
			for (int c = r; c < width - r - 1; c++) begin
				rowBits[r*resW + width - r + c] = X[width-r-1] & X[c];
			end
		end

		////////////////////////////////////////
		// Diagonal terms
		////////////////////////////////////////

		// x(i)x(i) = x(i), lower half
		for (int r = 0; r <= (width-1)/2; r++) begin
			rowBits[r*resW + 2*r] = X[r];
		end
		// Upper half, top row gets the sign square
		for (int r = 1; r <= width/2; r++) begin
			rowBits[r*resW + resW - 2*r] = X[width-r];
		end

		// Sign correction constants
		rowBits[resW-1] = ~X[width-1];
		rowBits[2*resW-1] = 1'b1;
		// Even widths split the correction over two rows
		if (width % 2 == 0) begin
			rowBits[(width/2-1)*resW + width - 1] = X[width-1];
			rowBits[(width/2)*resW + width - 1] = X[width-1];
		end else begin
			rowBits[(width/2)*resW + width] = X[width-1];
		end

		PP = rowBits;
	end

endmodule

// ==== verilog/SqrPipeReg.sv ====
// Elastic pipeline register
// Single entry valid/ready stage, payload type set per instance

`timescale 1ns/1ps

module SqrPipeReg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input payload_t inData,
	output logic outValid,
	input logic outReady,
	output payload_t outData
);

	// Accept when empty or draining this cycle
	assign inReady = ~outValid | outReady;

	// Occupancy flag
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	// Payload only moves on a transfer
	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			outData <= inData;
		end
	end

endmodule

// ==== verilog/SqrPkg.sv ====
// Squarer payload types
// Packed structs carried between the pipeline stages

`include "sqr_defs.svh"

package SqrPkg;

	////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////

	// Signed operand, input stage
	typedef struct packed {
		logic signed [`SQR_WIDTH-1:0] x;
	} operand_t;

	// Redundant sum/carry form after the CSA tree
	typedef struct packed {
		logic [`SQR_RES_WIDTH-1:0] sum;
		logic [`SQR_RES_WIDTH-1:0] carry;
	} csPair_t;

	// Final square, always non-negative
	typedef struct packed {
		logic [`SQR_RES_WIDTH-1:0] square;
	} result_t;

endpackage

// ==== verilog/SqrPrefixAdder.sv ====
// Sklansky parallel-prefix adder
// Resolves the CSA sum/carry pair into the final square, mod 2^width

`timescale 1ns/1ps
`include "sqr_defs.svh"

module SqrPrefixAdder (
	input SqrPkg::csPair_t cs,
	output SqrPkg::result_t y
);

	localparam int resW = `SQR_RES_WIDTH;
	localparam int levels = $clog2(resW);

	wire [resW-1:0] p0;
	wire [resW-1:0] carry;
	wire [levels:0][resW-1:0] gL;
	// Group propagate not needed after the last level
	wire [levels-1:0][resW-1:0] pL;

	// Bitwise generate and propagate
	assign p0 = cs.sum ^ cs.carry;
	assign gL[0] = cs.sum & cs.carry;
	assign pL[0] = p0;

	genvar lvl;
	genvar i;
	generate
		for (lvl = 0; lvl < levels; lvl++) begin : gLevel
			for (i = 0; i < resW; i++) begin : gBit
				if (((i >> lvl) & 1) == 1) begin : gNode
					// Top bit of the lower half block
					localparam int src = ((i >> lvl) << lvl) - 1;
					assign gL[lvl+1][i] = gL[lvl][i] | (pL[lvl][i] & gL[lvl][src]);
					if (lvl < levels - 1) begin : gProp
						assign pL[lvl+1][i] = pL[lvl][i] & pL[lvl][src];
					end
				end else begin : gPass
					assign gL[lvl+1][i] = gL[lvl][i];
					if (lvl < levels - 1) begin : gProp
						assign pL[lvl+1][i] = pL[lvl][i];
					end
				end
			end
		end
	endgenerate

	// No carry-in, carry-out discarded
	assign carry = {gL[levels][resW-2:0], 1'b0};
	assign y = '{square: p0 ^ carry};

endmodule

// ==== verilog/SqrReqAckIn.sv ====
// Four-phase operand receiver
// Turns a req/ack handshake into a valid/ready source for stage 1

`timescale 1ns/1ps

module SqrReqAckIn (
	input logic clk,
	input logic rst,
	input logic reqIn,
	output logic ackIn,
	input SqrPkg::operand_t xIn,
	output logic outValid,
	input logic outReady,
	output SqrPkg::operand_t outData
);

	typedef enum logic {
		stIdle,
		stAcked
	} state_t;

	state_t state;

	// Operand offered only before the acknowledge
	assign outValid = reqIn && (state == stIdle);
	assign outData = xIn;
	assign ackIn = (state == stAcked);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
		end else begin
			case (state)
				// Transfer into stage 1, ack next cycle
				stIdle: if (outValid && outReady) state <= stAcked;
				// Hold ack until request released
				stAcked: if (!reqIn) state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// ==== verilog/SqrReqAckOut.sv ====
// Four-phase result sender
// Takes one result from the pipeline and presents it on req/ack

`timescale 1ns/1ps

module SqrReqAckOut (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input SqrPkg::result_t inData,
	output logic reqOut,
	input logic ackOut,
	output SqrPkg::result_t yOut
);

	typedef enum logic [1:0] {
		stIdle,
		stReq,
		stWaitLow
	} state_t;

	state_t state;
	SqrPkg::result_t holdData;

	// Pipeline drained only between handshakes
	assign inReady = (state == stIdle);
	assign reqOut = (state == stReq);
	assign yOut = holdData;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: if (inValid) state <= stReq;
				// Drop request once acknowledged
				stReq: if (ackOut) state <= stWaitLow;
				// Return to zero before the next result
				stWaitLow: if (!ackOut) state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	// Holding register, stable for the whole request
	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			holdData <= inData;
		end
	end

endmodule

// ==== verilog/SqrTop.sv ====
// Pipelined signed squarer
// Req/ack in, three elastic stages around PP/CSA and prefix adder,
// req/ack out

`timescale 1ns/1ps
`include "sqr_defs.svh"

module SqrTop (
	input logic clk,
	input logic rst,
	input logic reqIn,
	output logic ackIn,
	input SqrPkg::operand_t xIn,
	output logic reqOut,
	input logic ackOut,
	output SqrPkg::result_t yOut
);

	////////////////////////////////////////
	// Stage links
	////////////////////////////////////////

	// Receiver to stage 1
	logic opValid;
	logic opReady;
	SqrPkg::operand_t opData;
	// Stage 1 to PP/CSA
	logic s1Valid;
	logic s1Ready;
	SqrPkg::operand_t s1Data;
	logic [`SQR_PP_ROWS*`SQR_RES_WIDTH-1:0] pp;
	SqrPkg::csPair_t csComb;
	// Stage 2 to adder
	logic s2Valid;
	logic s2Ready;
	SqrPkg::csPair_t s2Data;
	SqrPkg::result_t sqComb;
	// Stage 3 to sender
	logic s3Valid;
	logic s3Ready;
	SqrPkg::result_t s3Data;

	SqrReqAckIn reqAckIn_i (
		.clk(clk), .rst(rst), .reqIn(reqIn), .ackIn(ackIn), .xIn(xIn),
		.outValid(opValid), .outReady(opReady), .outData(opData)
	);

	SqrPipeReg #(.payload_t(SqrPkg::operand_t)) stage1_i (
		.clk(clk), .rst(rst), .inValid(opValid), .inReady(opReady), .inData(opData),
		.outValid(s1Valid), .outReady(s1Ready), .outData(s1Data)
	);

	// Partial products and carry-save reduction
	SqrPPGenSgn #(.width(`SQR_WIDTH)) ppGen_i (.X(s1Data.x), .PP(pp));
	SqrCsaTree csaTree_i (.pp(pp), .cs(csComb));

	SqrPipeReg #(.payload_t(SqrPkg::csPair_t)) stage2_i (
		.clk(clk), .rst(rst), .inValid(s1Valid), .inReady(s1Ready), .inData(csComb),
		.outValid(s2Valid), .outReady(s2Ready), .outData(s2Data)
	);

	// Carry-propagate stage
	SqrPrefixAdder adder_i (.cs(s2Data), .y(sqComb));

	SqrPipeReg #(.payload_t(SqrPkg::result_t)) stage3_i (
		.clk(clk), .rst(rst), .inValid(s2Valid), .inReady(s2Ready), .inData(sqComb),
		.outValid(s3Valid), .outReady(s3Ready), .outData(s3Data)
	);

	SqrReqAckOut reqAckOut_i (
		.clk(clk), .rst(rst), .inValid(s3Valid), .inReady(s3Ready), .inData(s3Data),
		.reqOut(reqOut), .ackOut(ackOut), .yOut(yOut)
	);

endmodule

// ==== verilog/sqr_defs.svh ====
// Squarer width macros
// Operand, result and partial-product row counts shared by all blocks

`ifndef SQR_DEFS_SVH
`define SQR_DEFS_SVH

// Operand width, two's complement
`define SQR_WIDTH 8

// Full square width
`define SQR_RES_WIDTH (2*`SQR_WIDTH)

// Generator rows incl. correction row
`define SQR_PP_ROWS (`SQR_WIDTH/2+1)

`endif
